// ==== Bender.yml ====
package:
  name: store_mcu

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/vec_cfg_pkg.sv
      - logic/mcu_ctrl_pkg.sv
      - logic/store_cfg_if.sv
      - logic/store_accept_ctrl.sv
      - logic/store_drain_ctrl.sv
      - logic/store_mcu_top.sv
  - target: test
    files:
      - sim/tb_store_mcu.sv

// ==== logic/mcu_ctrl_pkg.sv ====
/*
  State encodings of the store accept and store drain FSMs
*/
`default_nettype none

package mcu_ctrl_pkg;

  // Command acceptance and lane write side
  typedef enum logic [1:0] {
    ACC_IDLE,
    ACC_BUFFED,
    ACC_WRITE,
    ACC_WAIT
  } accept_state_e;

  // Buffer read and AXI write stream side
  typedef enum logic [1:0] {
    DRN_IDLE,
    DRN_UNIT,
    DRN_STRIDED,
    DRN_STRIDED_WAIT
  } drain_state_e;

endpackage

`default_nettype wire

// ==== logic/mcu_settings.svh ====
/*
  Field widths, encodings and timing constants of the store MCU
*/
`ifndef MCU_SETTINGS_SVH
`define MCU_SETTINGS_SVH

// Width of the SEW, LMUL and memory width codes
`define MCU_CODE_W 3

// Store type vector, packed as {unit, strided}
`define MCU_TYPE_W 2
`define MCU_TYPE_STRIDED 2'b01

// LMUL code with no legal grouping, also marks an EMUL out of range
`define MCU_LMUL_RSVD 3'd4

// Store data buffer read latency in cycles
`define MCU_RD_LAT 2

`endif

// ==== logic/store_accept_ctrl.sv ====
/*
  Store command acceptance, EMUL computation and configuration registers
  Lane write FSM that fills the store data buffer
*/
`timescale 1ns/1ps
`default_nettype none
`include "mcu_settings.svh"

module store_accept_ctrl (
  input  logic                   clk,
  input  logic                   rstn,
  // Scheduler command
  input  logic                   st_vld_i,
  output logic                   st_rdy_o,
  input  logic                   unit_i,
  input  logic                   strided_i,
  input  vec_cfg_pkg::sew_t      sew_i,
  input  vec_cfg_pkg::lmul_t     lmul_i,
  input  vec_cfg_pkg::width_t    width_i,
  // Buffer control
  output logic                   baseaddr_set_o,
  output logic                   cfg_update_o,
  output logic                   cntr_rst_o,
  output logic                   sbuff_wen_o,
  input  logic                   wdone_i,
  // Vector lanes
  input  logic                   lane_dvalid_i,
  output logic                   lane_rdy_o,
  // Hand-off to the drain side
  store_cfg_if.accept            cfg
);

  //////////////////////////////
  // Declarations
  //////////////////////////////

  vec_cfg_pkg::st_type_t        st_type;
  vec_cfg_pkg::st_mode_e        mode_in;
  logic [`MCU_CODE_W+1:0]       emul_log2;
  logic                         emul_fits;
  vec_cfg_pkg::lmul_t           emul;
  logic                         accept;

  vec_cfg_pkg::st_mode_e        mode_q;
  vec_cfg_pkg::sew_t            data_sew_q;
  vec_cfg_pkg::lmul_t           data_lmul_q;

  mcu_ctrl_pkg::accept_state_e  state_q;
  mcu_ctrl_pkg::accept_state_e  state_d;

  //////////////////////////////
  // Command decode and EMUL
  //////////////////////////////

  assign st_type = {unit_i, strided_i};
  assign mode_in = (st_type == `MCU_TYPE_STRIDED) ? vec_cfg_pkg::ST_STRIDED
                                                   : vec_cfg_pkg::ST_UNIT;

  // log2(EMUL) = log2(LMUL) + width - SEW, LMUL sign-extended
  assign emul_log2 = {{2{lmul_i[`MCU_CODE_W-1]}}, lmul_i}
                   + {2'b00, width_i}
                   - {2'b00, sew_i};

  // Result must fit the signed LMUL code, -4 is the reserved code anyway
  assign emul_fits = (emul_log2[`MCU_CODE_W+1:`MCU_CODE_W-1] ==
                      {3{emul_log2[`MCU_CODE_W-1]}});
  assign emul = emul_fits ? emul_log2[`MCU_CODE_W-1:0] : `MCU_LMUL_RSVD;

  assign accept = st_vld_i && st_rdy_o;

  // Configuration of the accepted store, effective width replaces SEW
  always_ff @(posedge clk) begin
    if (accept) begin
      mode_q      <= mode_in;
      data_sew_q  <= width_i;
      data_lmul_q <= emul;
    end
  end

  assign cfg.mode      = mode_q;
  assign cfg.data_sew  = data_sew_q;
  assign cfg.data_lmul = data_lmul_q;

  //////////////////////////////
  // Lane write FSM
  //////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= mcu_ctrl_pkg::ACC_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d        = state_q;
    st_rdy_o       = 1'b0;
    baseaddr_set_o = 1'b0;
    cfg_update_o   = 1'b0;
    cntr_rst_o     = 1'b0;
    lane_rdy_o     = 1'b0;
    sbuff_wen_o    = 1'b0;
    cfg.start      = 1'b0;

    case (state_q)
      mcu_ctrl_pkg::ACC_IDLE: begin
        st_rdy_o = 1'b1;
        if (st_vld_i) begin
          baseaddr_set_o = 1'b1;
          state_d        = mcu_ctrl_pkg::ACC_BUFFED;
        end
      end

      // New config is registered, push it to the buffer and wake the drain
      mcu_ctrl_pkg::ACC_BUFFED: begin
        cfg_update_o = 1'b1;
        cntr_rst_o   = 1'b1;
        cfg.start    = 1'b1;
        state_d      = mcu_ctrl_pkg::ACC_WRITE;
      end

      mcu_ctrl_pkg::ACC_WRITE: begin
        lane_rdy_o  = 1'b1;
        sbuff_wen_o = lane_dvalid_i;
        if (lane_dvalid_i && wdone_i) begin
          state_d = mcu_ctrl_pkg::ACC_WAIT;
        end
      end

      // Hold off the next command until the buffer is drained
      mcu_ctrl_pkg::ACC_WAIT: begin
        if (cfg.done) begin
          state_d = mcu_ctrl_pkg::ACC_IDLE;
        end
      end

      default: begin
        state_d = mcu_ctrl_pkg::ACC_IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/store_cfg_if.sv ====
/*
  Captured store configuration and start/done hand-off between the
  accept and drain controllers
*/
`timescale 1ns/1ps
`default_nettype none

interface store_cfg_if;

  vec_cfg_pkg::st_mode_e mode;
  vec_cfg_pkg::sew_t     data_sew;
  vec_cfg_pkg::lmul_t    data_lmul;

  // One-cycle pulses, start from accept and done from drain
  logic                  start;
  logic                  done;

  modport accept (
    output mode,
    output data_sew,
    output data_lmul,
    output start,
    input  done
  );

  modport drain (
    input  mode,
    input  data_sew,
    input  data_lmul,
    input  start,
    output done
  );

endinterface

`default_nettype wire

// ==== logic/store_drain_ctrl.sv ====
/*
  Store buffer read FSM with read-valid delay pipe
  Drives the AXI write stream valid, write start and base address update
*/
`timescale 1ns/1ps
`default_nettype none
`include "mcu_settings.svh"

module store_drain_ctrl (
  input  logic          clk,
  input  logic          rstn,
  // Store data buffer read side
  output logic          sbuff_ren_o,
  output logic          sbuff_read_stall_o,
  input  logic          sbuff_read_rdy_i,
  input  logic          sbuff_read_done_i,
  output logic          baseaddr_update_o,
  // AXI write master
  output logic          ctrl_wstart_o,
  input  logic          ctrl_wdone_i,
  output logic          wr_tvalid_o,
  input  logic          wr_tready_i,
  // Hand-off from the accept side
  store_cfg_if.drain    cfg
);

  //////////////////////////////
  // Declarations
  //////////////////////////////

  mcu_ctrl_pkg::drain_state_e  state_q;
  mcu_ctrl_pkg::drain_state_e  state_d;

  logic [`MCU_RD_LAT-1:0]      rvalid_q;
  logic                        read_done_q;
  logic                        burst_req;
  logic                        burst_req_q;
  logic                        buf_wait;
  logic                        beat;

  //////////////////////////////
  // Read issue and valid pipe
  //////////////////////////////

  // Burst request is up in both reading states
  assign burst_req = (state_q == mcu_ctrl_pkg::DRN_UNIT) ||
                     (state_q == mcu_ctrl_pkg::DRN_STRIDED);

  // Buffer still owes data but has none ready
  assign buf_wait = burst_req && !sbuff_read_rdy_i && !read_done_q;

  assign sbuff_ren_o = burst_req && sbuff_read_rdy_i && wr_tready_i && !read_done_q;

  // Freeze the buffer output and our valid pipe together
  assign sbuff_read_stall_o = (state_q == mcu_ctrl_pkg::DRN_STRIDED_WAIT) ||
                              (burst_req && (!wr_tready_i || buf_wait));

  assign wr_tvalid_o = burst_req && rvalid_q[`MCU_RD_LAT-1] && !buf_wait;
  assign beat        = wr_tvalid_o && wr_tready_i;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rvalid_q <= '0;
    end else if (!sbuff_read_stall_o) begin
      rvalid_q <= {rvalid_q[`MCU_RD_LAT-2:0], sbuff_ren_o};
    end
  end

  // Sticky once the last element has been read out of the buffer
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      read_done_q <= 1'b0;
    end else if (cfg.start) begin
      read_done_q <= 1'b0;
    end else if (sbuff_ren_o && sbuff_read_done_i) begin
      read_done_q <= 1'b1;
    end
  end

  // Write start is the rising edge of the burst request
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      burst_req_q <= 1'b0;
    end else begin
      burst_req_q <= burst_req;
    end
  end

  assign ctrl_wstart_o = burst_req && !burst_req_q;

  //////////////////////////////
  // Drain FSM
  //////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= mcu_ctrl_pkg::DRN_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d           = state_q;
    baseaddr_update_o = 1'b0;
    cfg.done          = 1'b0;

    case (state_q)
      mcu_ctrl_pkg::DRN_IDLE: begin
        if (cfg.start) begin
          if (cfg.mode == vec_cfg_pkg::ST_STRIDED) begin
            state_d = mcu_ctrl_pkg::DRN_STRIDED;
          end else begin
            state_d = mcu_ctrl_pkg::DRN_UNIT;
          end
        end
      end

      // One burst for the whole vector
      mcu_ctrl_pkg::DRN_UNIT: begin
        if (ctrl_wdone_i) begin
          cfg.done = 1'b1;
          state_d  = mcu_ctrl_pkg::DRN_IDLE;
        end
      end

      // One element per burst
      mcu_ctrl_pkg::DRN_STRIDED: begin
        if (beat) begin
          state_d = mcu_ctrl_pkg::DRN_STRIDED_WAIT;
        end
      end

      mcu_ctrl_pkg::DRN_STRIDED_WAIT: begin
        if (ctrl_wdone_i) begin
          baseaddr_update_o = 1'b1;
          if ((rvalid_q == '0) && read_done_q) begin
            cfg.done = 1'b1;
            state_d  = mcu_ctrl_pkg::DRN_IDLE;
          end else begin
            state_d = mcu_ctrl_pkg::DRN_STRIDED;
          end
        end
      end

      default: begin
        state_d = mcu_ctrl_pkg::DRN_IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/store_mcu_top.sv ====
/*
  Store side of the vector memory control unit
  Accept and drain controllers joined by the store configuration interface
*/
`timescale 1ns/1ps
`default_nettype none

module store_mcu_top (
  input  logic                   clk,
  input  logic                   rstn,
  // Scheduler command
  input  logic                   st_vld_i,
  output logic                   st_rdy_o,
  input  logic                   unit_i,
  input  logic                   strided_i,
  input  vec_cfg_pkg::sew_t      sew_i,
  input  vec_cfg_pkg::lmul_t     lmul_i,
  input  vec_cfg_pkg::width_t    width_i,
  // Buffer configuration
  output vec_cfg_pkg::sew_t      cfg_data_sew_o,
  output vec_cfg_pkg::lmul_t     cfg_data_lmul_o,
  output logic                   cfg_update_o,
  output logic                   cntr_rst_o,
  output logic                   baseaddr_set_o,
  output logic                   baseaddr_update_o,
  // Buffer write and read control
  output logic                   sbuff_wen_o,
  input  logic                   wdone_i,
  output logic                   sbuff_ren_o,
  output logic                   sbuff_read_stall_o,
  input  logic                   sbuff_read_rdy_i,
  input  logic                   sbuff_read_done_i,
  // Vector lanes
  input  logic                   lane_dvalid_i,
  output logic                   lane_rdy_o,
  // AXI write master
  output logic                   ctrl_wstart_o,
  input  logic                   ctrl_wdone_i,
  output logic                   wr_tvalid_o,
  input  logic                   wr_tready_i
);

  store_cfg_if cfg_bus ();

  store_accept_ctrl u_accept (
    .clk            (clk),
    .rstn           (rstn),
    .st_vld_i       (st_vld_i),
    .st_rdy_o       (st_rdy_o),
    .unit_i         (unit_i),
    .strided_i      (strided_i),
    .sew_i          (sew_i),
    .lmul_i         (lmul_i),
    .width_i        (width_i),
    .baseaddr_set_o (baseaddr_set_o),
    .cfg_update_o   (cfg_update_o),
    .cntr_rst_o     (cntr_rst_o),
    .sbuff_wen_o    (sbuff_wen_o),
    .wdone_i        (wdone_i),
    .lane_dvalid_i  (lane_dvalid_i),
    .lane_rdy_o     (lane_rdy_o),
    .cfg            (cfg_bus.accept)
  );

  store_drain_ctrl u_drain (
    .clk                (clk),
    .rstn               (rstn),
    .sbuff_ren_o        (sbuff_ren_o),
    .sbuff_read_stall_o (sbuff_read_stall_o),
    .sbuff_read_rdy_i   (sbuff_read_rdy_i),
    .sbuff_read_done_i  (sbuff_read_done_i),
    .baseaddr_update_o  (baseaddr_update_o),
    .ctrl_wstart_o      (ctrl_wstart_o),
    .ctrl_wdone_i       (ctrl_wdone_i),
    .wr_tvalid_o        (wr_tvalid_o),
    .wr_tready_i        (wr_tready_i),
    .cfg                (cfg_bus.drain)
  );

  // Captured configuration goes straight out to the buffer
  assign cfg_data_sew_o  = cfg_bus.data_sew;
  assign cfg_data_lmul_o = cfg_bus.data_lmul;

endmodule

`default_nettype wire

// ==== logic/vec_cfg_pkg.sv ====
/*
  Vector configuration types: SEW, LMUL, memory width, store type and mode
*/
`default_nettype none
`include "mcu_settings.svh"

package vec_cfg_pkg;

  // Element width code, 0..3 is 8, 16, 32, 64 bits
  typedef logic [`MCU_CODE_W-1:0] sew_t;

  // Register grouping as signed log2
  // 0..3 is 1, 2, 4, 8 and 5..7 is 1/8, 1/4, 1/2
  typedef logic [`MCU_CODE_W-1:0] lmul_t;

  // Memory element width, coded like SEW
  typedef logic [`MCU_CODE_W-1:0] width_t;

  // One-hot store type from the scheduler
  typedef logic [`MCU_TYPE_W-1:0] st_type_t;

  typedef enum logic {
    ST_UNIT,
    ST_STRIDED
  } st_mode_e;

endpackage

`default_nettype wire

// ==== sim/tb_store_mcu.sv ====
/*
  Testbench of the store MCU with buffer and AXI write models
  Random commands, lane writes and back-pressure checked against counters
*/
`timescale 1ns/1ps
`default_nettype none

module tb_store_mcu;

  localparam int WAIT_LIMIT = 2000;

  //////////////////////////////
  // DUT signals
  //////////////////////////////

  logic                  clk;
  logic                  rstn;
  logic                  st_vld_i;
  logic                  st_rdy_o;
  logic                  unit_i;
  logic                  strided_i;
  vec_cfg_pkg::sew_t     sew_i;
  vec_cfg_pkg::lmul_t    lmul_i;
  vec_cfg_pkg::width_t   width_i;
  vec_cfg_pkg::sew_t     cfg_data_sew_o;
  vec_cfg_pkg::lmul_t    cfg_data_lmul_o;
  logic                  cfg_update_o;
  logic                  cntr_rst_o;
  logic                  baseaddr_set_o;
  logic                  baseaddr_update_o;
  logic                  sbuff_wen_o;
  logic                  wdone_i;
  logic                  sbuff_ren_o;
  logic                  sbuff_read_stall_o;
  logic                  sbuff_read_rdy_i;
  logic                  sbuff_read_done_i;
  logic                  lane_dvalid_i;
  logic                  lane_rdy_o;
  logic                  ctrl_wstart_o;
  logic                  ctrl_wdone_i;
  logic                  wr_tvalid_o;
  logic                  wr_tready_i;

  // Model state of the running command
  int  seed = 53;
  int  errors = 0;
  int  tests_run = 0;
  int  tests_passed = 0;
  bit  timed_out = 0;
  bit  active = 0;
  bit  cur_strided;
  int  n_items;
  int  cycle_cnt = 0;
  int  hs_cycle;
  int  wen_cnt;
  int  read_cnt;
  int  beat_cnt;
  int  wstart_cnt;
  int  baddr_set_cnt;
  int  baddr_upd_cnt;
  int  cfg_upd_cnt;
  int  cntr_rst_cnt;
  int  beats_since_wdone;
  bit  wdone_given;
  vec_cfg_pkg::sew_t   exp_sew;
  vec_cfg_pkg::lmul_t  exp_lmul;

  // Outputs captured at the falling edge
  logic s_hs, s_cfg_update, s_cntr_rst, s_wen, s_dvalid, s_lane_rdy;
  logic s_ren, s_wstart, s_baddr_upd, s_ctrl_wdone, s_beat;
  logic s_baddr_set, s_stall, s_hold;
  vec_cfg_pkg::sew_t   s_cfg_sew;
  vec_cfg_pkg::lmul_t  s_cfg_lmul;

  store_mcu_top dut (
    .clk                (clk),
    .rstn               (rstn),
    .st_vld_i           (st_vld_i),
    .st_rdy_o           (st_rdy_o),
    .unit_i             (unit_i),
    .strided_i          (strided_i),
    .sew_i              (sew_i),
    .lmul_i             (lmul_i),
    .width_i            (width_i),
    .cfg_data_sew_o     (cfg_data_sew_o),
    .cfg_data_lmul_o    (cfg_data_lmul_o),
    .cfg_update_o       (cfg_update_o),
    .cntr_rst_o         (cntr_rst_o),
    .baseaddr_set_o     (baseaddr_set_o),
    .baseaddr_update_o  (baseaddr_update_o),
    .sbuff_wen_o        (sbuff_wen_o),
    .wdone_i            (wdone_i),
    .sbuff_ren_o        (sbuff_ren_o),
    .sbuff_read_stall_o (sbuff_read_stall_o),
    .sbuff_read_rdy_i   (sbuff_read_rdy_i),
    .sbuff_read_done_i  (sbuff_read_done_i),
    .lane_dvalid_i      (lane_dvalid_i),
    .lane_rdy_o         (lane_rdy_o),
    .ctrl_wstart_o      (ctrl_wstart_o),
    .ctrl_wdone_i       (ctrl_wdone_i),
    .wr_tvalid_o        (wr_tvalid_o),
    .wr_tready_i        (wr_tready_i)
  );

  always #20 clk = ~clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic bit rand_pct(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // Signed log2 of the grouping where codes 5..7 are the fractional ones
  function automatic int lmul_log2(input logic [2:0] code);
    if (code[2]) begin
      return int'(code) - 8;
    end
    return int'(code);
  endfunction

  function automatic logic [2:0] log2_to_code(input int r);
    return r[2:0];
  endfunction

  task automatic report_mismatch(input string name, input int got, input int exp);
    $display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_error(input string what);
    $display("ERROR at %0t: %s", $time, what);
    errors++;
  endtask

  //////////////////////////////
  // Sampling and models
  //////////////////////////////

  always @(negedge clk) begin
    s_hs         = st_vld_i && st_rdy_o;
    s_cfg_update = cfg_update_o;
    s_cntr_rst   = cntr_rst_o;
    s_cfg_sew    = cfg_data_sew_o;
    s_cfg_lmul   = cfg_data_lmul_o;
    s_wen        = sbuff_wen_o;
    s_dvalid     = lane_dvalid_i;
    s_lane_rdy   = lane_rdy_o;
    s_ren        = sbuff_ren_o;
    s_wstart     = ctrl_wstart_o;
    s_baddr_set  = baseaddr_set_o;
    s_baddr_upd  = baseaddr_update_o;
    s_ctrl_wdone = ctrl_wdone_i;
    s_stall      = sbuff_read_stall_o;
    s_beat       = wr_tvalid_o && wr_tready_i;
    s_hold       = wr_tvalid_o && !wr_tready_i;
  end

  // Buffer and AXI write master models stepped once per clock on the captured outputs
  always @(posedge clk) begin
    if (active) begin
      if (s_hs) begin
        hs_cycle = cycle_cnt;
      end
      if (s_baddr_set) begin
        baddr_set_cnt++;
        if (!s_hs) begin
          report_error("baseaddr_set_o without a command handshake");
        end
      end
      if (s_cfg_update) begin
        cfg_upd_cnt++;
        if (cycle_cnt != hs_cycle + 1) begin
          report_error("cfg_update_o not in the cycle after the handshake");
        end
        if (s_cfg_sew != exp_sew) begin
          report_mismatch("cfg_data_sew_o", int'(s_cfg_sew), int'(exp_sew));
        end
        if (s_cfg_lmul != exp_lmul) begin
          report_mismatch("cfg_data_lmul_o", int'(s_cfg_lmul), int'(exp_lmul));
        end
      end
      if (s_cntr_rst) begin
        cntr_rst_cnt++;
        if (cycle_cnt != hs_cycle + 1) begin
          report_error("cntr_rst_o not in the cycle after the handshake");
        end
      end
      if (s_wen && !s_dvalid) begin
        report_error("sbuff_wen_o high without lane_dvalid_i");
      end
      if (s_lane_rdy && wen_cnt >= n_items) begin
        report_error("lane_rdy_o still high after the last lane write");
      end
      if ((s_ren || s_beat) && s_stall) begin
        report_error("sbuff_read_stall_o high while the read pipe moves");
      end
      if (s_hold && !s_stall) begin
        report_error("sbuff_read_stall_o low under write back-pressure");
      end
      if (s_wen) wen_cnt++;
      if (s_ren) read_cnt++;
      if (s_wstart) wstart_cnt++;
      if (s_baddr_upd) baddr_upd_cnt++;
      if (s_ctrl_wdone) beats_since_wdone = 0;
      if (s_beat) begin
        beat_cnt++;
        beats_since_wdone++;
        if (cur_strided && beats_since_wdone > 1) begin
          report_error("more than one strided beat before ctrl_wdone_i");
        end
      end

      // Reads only of items the lanes have already written
      lane_dvalid_i     <= (wen_cnt < n_items) && rand_pct(75);
      wdone_i           <= (wen_cnt == n_items - 1);
      sbuff_read_rdy_i  <= (read_cnt < wen_cnt) && rand_pct(80);
      sbuff_read_done_i <= (read_cnt == n_items - 1);
      wr_tready_i       <= rand_pct(70);
      if (cur_strided) begin
        ctrl_wdone_i <= s_beat;
      end else begin
        ctrl_wdone_i <= (beat_cnt == n_items) && !wdone_given;
        if (beat_cnt == n_items) wdone_given = 1'b1;
      end
    end else begin
      lane_dvalid_i     <= 1'b0;
      wdone_i           <= 1'b0;
      sbuff_read_rdy_i  <= 1'b0;
      sbuff_read_done_i <= 1'b0;
      wr_tready_i       <= 1'b0;
      ctrl_wdone_i      <= 1'b0;
    end
    cycle_cnt++;
  end

  //////////////////////////////
  // Command sequences
  //////////////////////////////

  // mode_sel is 0 for random, 1 for unit and 2 for strided
  task automatic run_store(input int mode_sel, input int gap_max);
    int  wait_cnt;
    int  tries;
    int  r;
    int  gap;
    bit  hs;
    bit  back;
    logic [2:0] sew;
    logic [2:0] lmul;
    logic [2:0] width;
    logic [2:0] try_sew;
    logic [2:0] try_lmul;
    logic [2:0] try_width;

    @(negedge clk);
    sew   = 3'd0;
    lmul  = 3'd0;
    width = 3'd0;
    tries = 0;
    while (tries < 50) begin
      try_sew   = 3'(rand_range(0, 3));
      try_width = 3'(rand_range(0, 3));
      try_lmul  = 3'((rand_range(0, 6) + 5) % 8);
      r = lmul_log2(try_lmul) + int'(try_width) - int'(try_sew);
      if (r >= -3 && r <= 3) begin
        sew   = try_sew;
        lmul  = try_lmul;
        width = try_width;
        tries = 50;
      end
      tries++;
    end
    if (mode_sel == 0) begin
      cur_strided = rand_pct(50);
    end else begin
      cur_strided = (mode_sel == 2);
    end
    n_items  = rand_range(1, 8);
    gap      = rand_range(0, gap_max);
    exp_sew  = width;
    exp_lmul = log2_to_code(lmul_log2(lmul) + int'(width) - int'(sew));
    hs_cycle = -10;
    wen_cnt = 0;
    read_cnt = 0;
    beat_cnt = 0;
    wstart_cnt = 0;
    baddr_set_cnt = 0;
    baddr_upd_cnt = 0;
    cfg_upd_cnt = 0;
    cntr_rst_cnt = 0;
    beats_since_wdone = 0;
    wdone_given = 1'b0;
    active = 1'b1;

    repeat (gap) @(posedge clk);
    @(posedge clk);
    st_vld_i  <= 1'b1;
    unit_i    <= !cur_strided;
    strided_i <= cur_strided;
    sew_i     <= sew;
    lmul_i    <= lmul;
    width_i   <= width;

    wait_cnt = 0;
    hs = 1'b0;
    while (!hs && wait_cnt < WAIT_LIMIT) begin
      @(negedge clk);
      hs = st_vld_i && st_rdy_o;
      wait_cnt++;
    end
    if (!hs) begin
      report_error("no command handshake within the timeout");
      timed_out = 1'b1;
      active    = 1'b0;
      return;
    end
    @(posedge clk);
    st_vld_i <= 1'b0;

    // Store is over once the unit takes commands again
    wait_cnt = 0;
    back = 1'b0;
    while (!back && wait_cnt < WAIT_LIMIT) begin
      @(negedge clk);
      back = st_rdy_o;
      wait_cnt++;
    end
    if (!back) begin
      report_error("st_rdy_o did not return within the timeout");
      timed_out = 1'b1;
      active    = 1'b0;
      return;
    end

    if (baddr_set_cnt != 1) report_mismatch("baseaddr_set_o pulses", baddr_set_cnt, 1);
    if (cfg_upd_cnt != 1) report_mismatch("cfg_update_o pulses", cfg_upd_cnt, 1);
    if (cntr_rst_cnt != 1) report_mismatch("cntr_rst_o pulses", cntr_rst_cnt, 1);
    if (wen_cnt != n_items) report_mismatch("sbuff_wen_o beats", wen_cnt, n_items);
    if (read_cnt != n_items) report_mismatch("sbuff_ren_o reads", read_cnt, n_items);
    if (beat_cnt != n_items) report_mismatch("wr_tvalid_o beats", beat_cnt, n_items);
    if (wstart_cnt != (cur_strided ? n_items : 1)) begin
      report_mismatch("ctrl_wstart_o pulses", wstart_cnt, cur_strided ? n_items : 1);
    end
    if (baddr_upd_cnt != (cur_strided ? n_items : 0)) begin
      report_mismatch("baseaddr_update_o pulses", baddr_upd_cnt, cur_strided ? n_items : 0);
    end
    active = 1'b0;
  endtask

  task automatic run_test(input int id, input string name, input int count,
                          input int mode_sel, input int gap_max);
    int err_before;

    if (timed_out) begin
      return;
    end
    err_before = errors;
    for (int i = 0; i < count && !timed_out; i++) begin
      run_store(mode_sel, gap_max);
    end
    tests_run++;
    if (errors == err_before) begin
      tests_passed++;
      $display("test %0d %s: ok", id, name);
    end else begin
      $display("test %0d %s: %0d errors", id, name, errors - err_before);
    end
  endtask

  task automatic check_reset_state();
    int err_before;

    err_before = errors;
    @(negedge clk);
    if (lane_rdy_o !== 1'b0) report_mismatch("lane_rdy_o", int'(lane_rdy_o), 0);
    if (sbuff_wen_o !== 1'b0) report_mismatch("sbuff_wen_o", int'(sbuff_wen_o), 0);
    if (sbuff_ren_o !== 1'b0) report_mismatch("sbuff_ren_o", int'(sbuff_ren_o), 0);
    if (wr_tvalid_o !== 1'b0) report_mismatch("wr_tvalid_o", int'(wr_tvalid_o), 0);
    if (ctrl_wstart_o !== 1'b0) report_mismatch("ctrl_wstart_o", int'(ctrl_wstart_o), 0);
    if (cfg_update_o !== 1'b0) report_mismatch("cfg_update_o", int'(cfg_update_o), 0);
    if (baseaddr_update_o !== 1'b0) begin
      report_mismatch("baseaddr_update_o", int'(baseaddr_update_o), 0);
    end
    if (st_rdy_o !== 1'b1) report_mismatch("st_rdy_o", int'(st_rdy_o), 1);
    tests_run++;
    if (errors == err_before) begin
      tests_passed++;
      $display("test 1 reset state: ok");
    end else begin
      $display("test 1 reset state: %0d errors", errors - err_before);
    end
  endtask

  initial begin
    clk               = 1'b0;
    rstn              = 1'b0;
    st_vld_i          = 1'b0;
    unit_i            = 1'b0;
    strided_i         = 1'b0;
    sew_i             = '0;
    lmul_i            = '0;
    width_i           = '0;
    wdone_i           = 1'b0;
    sbuff_read_rdy_i  = 1'b0;
    sbuff_read_done_i = 1'b0;
    lane_dvalid_i     = 1'b0;
    ctrl_wdone_i      = 1'b0;
    wr_tready_i       = 1'b0;

    repeat (2) @(posedge clk);
    rstn <= 1'b1;

    check_reset_state();
    run_test(2, "configuration capture", 8, 0, 1);
    run_test(3, "lane write", 6, 0, 1);
    run_test(4, "unit store", 8, 1, 1);
    run_test(5, "strided store", 8, 2, 1);
    run_test(6, "back-to-back commands", 20, 0, 2);

    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_passed, tests_run - tests_passed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+logic
logic/vec_cfg_pkg.sv
logic/mcu_ctrl_pkg.sv
logic/store_cfg_if.sv
logic/store_accept_ctrl.sv
logic/store_drain_ctrl.sv
logic/store_mcu_top.sv
sim/tb_store_mcu.sv
